//--- common/synthPkg.sv
// Shared widths, register map and timing constants of the wavetable synth
// MIDI_BIT_CYCLES is sized for simulation, hardware at 50 MHz needs 1600
// Note steps cover octave 0 only and are shifted up once per octave
package synthPkg;

	// --------------------------------------------------
	// Sample and phase paths
	// --------------------------------------------------
	localparam int SAMPLE_W = 16;
	localparam int MEM_ADDR_W = 18;
	// Phase is word address plus fraction
	localparam int FRAC_W = 8;
	localparam int PHASE_W = MEM_ADDR_W + FRAC_W;
	localparam int STEP_W = 16;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	localparam int CSR_ADDR_W = 4;
	localparam int CSR_DATA_W = 32;
	localparam logic [CSR_ADDR_W-1:0] REG_CTRL = 4'd0;
	localparam logic [CSR_ADDR_W-1:0] REG_WAVE_START = 4'd1;
	localparam logic [CSR_ADDR_W-1:0] REG_WAVE_END = 4'd2;
	localparam logic [CSR_ADDR_W-1:0] REG_STATUS = 4'd3;
	// REG_CTRL fields
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_LOOP_BIT = 1;

	// --------------------------------------------------
	// MIDI
	// --------------------------------------------------
	localparam logic [15:0] MIDI_BIT_CYCLES = 16'd32;
	// Status nibbles of the channel messages we act on
	localparam logic [3:0] MIDI_NOTE_OFF = 4'h8;
	localparam logic [3:0] MIDI_NOTE_ON = 4'h9;
	// Octave 0 steps, roughly one semitone apart
	localparam logic [0:11][STEP_W-1:0] NOTE_BASE_STEP = '{
		16'd16, 16'd17, 16'd18, 16'd19, 16'd20, 16'd21,
		16'd23, 16'd24, 16'd25, 16'd27, 16'd28, 16'd30
	};

	// --------------------------------------------------
	// I2S
	// --------------------------------------------------
	// sClk cycles per half bit clock
	localparam int I2S_BCLK_DIV = 2;
	// 32 bit clocks per stereo frame
	localparam int I2S_FRAME_CYCLES = 64 * I2S_BCLK_DIV;

endpackage

//--- compile.f
common/synthPkg.sv
rtl/synthCsr.sv
midi/midiRx.sv
midi/noteDecoder.sv
wave/waveFetch.sv
i2s/i2sTx.sv
rtl/synthTop.sv
tests/synthTb.sv

//--- i2s/i2sTx.sv
// I2S transmitter, 32 bit clocks per frame, same sample left and right
// Bit clock is sClk divided by twice I2S_BCLK_DIV
// A frame with no sample ready by its first bit sends zeros
`timescale 1ns/1ps

module i2sTx
(
	input  logic sClk,
	input  logic rstN,
	input  logic sampleValid,
	output logic sampleReady,
	input  logic [synthPkg::SAMPLE_W-1:0] sampleData,
	output logic i2sBclk,
	output logic i2sLrclk,
	output logic i2sSdata
);

	logic [$clog2(synthPkg::I2S_BCLK_DIV + 1)-1:0] divCnt;
	logic tick;
	logic fallEdge;
	logic [4:0] bitCnt;
	logic [4:0] nextSlot;
	logic [2*synthPkg::SAMPLE_W-1:0] shiftReg;
	logic [synthPkg::SAMPLE_W-1:0] holdData;
	logic holdValid;
	logic underrun;
	logic [15:0] underrunCnt;

	assign tick = divCnt == ($bits(divCnt))'(synthPkg::I2S_BCLK_DIV - 1);
	assign fallEdge = tick && i2sBclk;
	assign nextSlot = bitCnt + 5'd1;

	// Window from last slot of the frame up to the load edge
	assign sampleReady = !holdValid && (bitCnt == 5'd31 || (bitCnt == 5'd0 && !fallEdge));

	// --------------------------------------------------
	// Bit clock, word select and serializer
	// --------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= '0;
			i2sBclk <= 1'b0;
			bitCnt <= 5'd31;
			i2sLrclk <= 1'b0;
			i2sSdata <= 1'b0;
			shiftReg <= '0;
			holdValid <= 1'b0;
			underrun <= 1'b0;
			underrunCnt <= '0;
		end
		else
		begin
			underrun <= 1'b0;
			divCnt <= tick ? '0 : divCnt + 1'b1;
			if (tick)
				i2sBclk <= !i2sBclk;
			if (sampleValid && sampleReady)
				holdValid <= 1'b1;

			// Everything moves on the falling bit clock edge
			if (fallEdge)
			begin
				bitCnt <= nextSlot;
				i2sLrclk <= nextSlot[4];
				// Slot 1 carries the left MSB, one bit after word select
				if (nextSlot == 5'd1)
				begin
					holdValid <= 1'b0;
					if (holdValid)
					begin
						i2sSdata <= holdData[synthPkg::SAMPLE_W-1];
						shiftReg <= {holdData[synthPkg::SAMPLE_W-2:0], holdData, 1'b0};
					end
					else
					begin
						i2sSdata <= 1'b0;
						shiftReg <= '0;
						underrun <= 1'b1;
						if (underrunCnt != 16'hffff)
							underrunCnt <= underrunCnt + 16'd1;
					end
				end
				else
				begin
					i2sSdata <= shiftReg[2*synthPkg::SAMPLE_W-1];
					shiftReg <= {shiftReg[2*synthPkg::SAMPLE_W-2:0], 1'b0};
				end
			end
		end
	end

	always_ff @(posedge sClk)
	begin
		if (sampleValid && sampleReady)
			holdData <= sampleData;
	end

endmodule

//--- midi/midiRx.sv
// 8N1 receiver for the MIDI line, MIDI_BIT_CYCLES sClk cycles per bit
// Start bit is checked at mid-bit, glitches back to idle
// A byte with a low stop bit is dropped, there is no error flag
`timescale 1ns/1ps

module midiRx
(
	input  logic sClk,
	input  logic rstN,
	input  logic midiIn,
	output logic [7:0] rxByte,
	output logic rxValid
);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxStateType;

	rxStateType state;
	logic midiSync1;
	logic midiSync2;
	logic midiPrev;
	logic [15:0] bitTimer;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic halfEnd;
	logic bitEnd;

	// Mid-bit of start, then one full bit to each following mid-bit
	assign halfEnd = bitTimer == (synthPkg::MIDI_BIT_CYCLES >> 1) - 16'd1;
	assign bitEnd = bitTimer == synthPkg::MIDI_BIT_CYCLES - 16'd1;

	// --------------------------------------------------
	// Input synchronizer and edge history
	// --------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			// Idle line is high
			midiSync1 <= 1'b1;
			midiSync2 <= 1'b1;
			midiPrev <= 1'b1;
		end
		else
		begin
			midiSync1 <= midiIn;
			midiSync2 <= midiSync1;
			midiPrev <= midiSync2;
		end
	end

	// --------------------------------------------------
	// Bit timing FSM
	// --------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			bitTimer <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			case (state)
				IDLE:
				begin
					bitTimer <= '0;
					// Falling edge opens a start bit
					if (midiPrev && !midiSync2)
						state <= START;
				end
				START:
				begin
					if (halfEnd)
					begin
						bitTimer <= '0;
						bitIdx <= '0;
						// High again at mid-bit means glitch
						state <= midiSync2 ? IDLE : DATA;
					end
					else
						bitTimer <= bitTimer + 16'd1;
				end
				DATA:
				begin
					if (bitEnd)
					begin
						bitTimer <= '0;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7)
							state <= STOP;
					end
					else
						bitTimer <= bitTimer + 16'd1;
				end
				STOP:
				begin
					if (bitEnd)
					begin
						bitTimer <= '0;
						state <= IDLE;
						rxValid <= midiSync2;
					end
					else
						bitTimer <= bitTimer + 16'd1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sClk)
	begin
		if (state == DATA && bitEnd)
			shiftReg <= {midiSync2, shiftReg[7:1]};
		if (state == STOP && bitEnd && midiSync2)
			rxByte <= shiftReg;
	end

endmodule

//--- midi/noteDecoder.sv
// MIDI parser for note-on and note-off on any channel, running status kept
// Other channel messages and their data bytes are skipped
// Realtime bytes pass through without touching running status
`timescale 1ns/1ps

module noteDecoder
(
	input  logic sClk,
	input  logic rstN,
	input  logic [7:0] rxByte,
	input  logic rxValid,
	output logic notePlay,
	output logic [synthPkg::STEP_W-1:0] noteStep,
	output logic [6:0] noteNum,
	output logic noteStart
);

	logic [7:0] runStatus;
	logic haveData0;
	logic [6:0] data0;
	logic isNoteMsg;
	logic [3:0] noteIdx;
	logic [3:0] octave;
	logic [synthPkg::STEP_W-1:0] nextStep;

	assign isNoteMsg = (runStatus[7:4] == synthPkg::MIDI_NOTE_OFF)
		|| (runStatus[7:4] == synthPkg::MIDI_NOTE_ON);

	// Octave 0 step shifted up by the octave, note 127 still fits
	assign noteIdx = 4'(data0 % 7'd12);
	assign octave = 4'(data0 / 7'd12);
	assign nextStep = synthPkg::NOTE_BASE_STEP[noteIdx] << octave;

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			runStatus <= '0;
			haveData0 <= 1'b0;
			data0 <= '0;
			notePlay <= 1'b0;
			noteStep <= '0;
			noteNum <= '0;
			noteStart <= 1'b0;
		end
		else
		begin
			noteStart <= 1'b0;
			if (rxValid)
			begin
				if (rxByte[7])
				begin
					// Status byte, F8 and up are realtime
					if (rxByte < 8'hf8)
					begin
						runStatus <= rxByte;
						haveData0 <= 1'b0;
					end
				end
				else if (isNoteMsg)
				begin
					if (!haveData0)
					begin
						data0 <= rxByte[6:0];
						haveData0 <= 1'b1;
					end
					else
					begin
						haveData0 <= 1'b0;
						// Velocity zero counts as note-off
						if (runStatus[7:4] == synthPkg::MIDI_NOTE_ON && rxByte[6:0] != 7'd0)
						begin
							notePlay <= 1'b1;
							noteNum <= data0;
							noteStep <= nextStep;
							noteStart <= 1'b1;
						end
						else if (data0 == noteNum)
							notePlay <= 1'b0;
					end
				end
			end
		end
	end

endmodule

//--- rtl/synthCsr.sv
// Control and status registers on a one-cycle write strobe bus
// Reads are combinational, unmapped addresses return zero
// Window end must stay above window start while playback is enabled
`timescale 1ns/1ps

module synthCsr
(
	input  logic sClk,
	input  logic rstN,
	input  logic csrWrEn,
	input  logic [synthPkg::CSR_ADDR_W-1:0] csrAddr,
	input  logic [synthPkg::CSR_DATA_W-1:0] csrWrData,
	output logic [synthPkg::CSR_DATA_W-1:0] csrRdData,
	output logic playEnable,
	output logic loopEnable,
	output logic [synthPkg::MEM_ADDR_W-1:0] waveStart,
	output logic [synthPkg::MEM_ADDR_W-1:0] waveEnd,
	input  logic waveDone,
	input  logic notePlay,
	input  logic [6:0] noteNum
);

	logic doneFlag;
	logic ctrlWrite;

	assign ctrlWrite = csrWrEn && (csrAddr == synthPkg::REG_CTRL);

	// --------------------------------------------------
	// Write side
	// --------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			playEnable <= 1'b0;
			loopEnable <= 1'b0;
			waveStart <= '0;
			waveEnd <= '0;
		end
		else if (csrWrEn)
		begin
			case (csrAddr)
				synthPkg::REG_CTRL:
				begin
					playEnable <= csrWrData[synthPkg::CTRL_EN_BIT];
					loopEnable <= csrWrData[synthPkg::CTRL_LOOP_BIT];
				end
				synthPkg::REG_WAVE_START: waveStart <= csrWrData[synthPkg::MEM_ADDR_W-1:0];
				synthPkg::REG_WAVE_END: waveEnd <= csrWrData[synthPkg::MEM_ADDR_W-1:0];
				// Status is read only
				default: ;
			endcase
		end
	end

	// Sticky done, a new end of window wins over the clearing write
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
			doneFlag <= 1'b0;
		else if (waveDone)
			doneFlag <= 1'b1;
		else if (ctrlWrite)
			doneFlag <= 1'b0;
	end

	// --------------------------------------------------
	// Read mux
	// --------------------------------------------------
	always_comb
	begin
		csrRdData = '0;
		case (csrAddr)
			synthPkg::REG_CTRL:
			begin
				csrRdData[synthPkg::CTRL_EN_BIT] = playEnable;
				csrRdData[synthPkg::CTRL_LOOP_BIT] = loopEnable;
			end
			synthPkg::REG_WAVE_START: csrRdData[synthPkg::MEM_ADDR_W-1:0] = waveStart;
			synthPkg::REG_WAVE_END: csrRdData[synthPkg::MEM_ADDR_W-1:0] = waveEnd;
			synthPkg::REG_STATUS:
			begin
				csrRdData[0] = doneFlag;
				csrRdData[1] = notePlay;
				csrRdData[14:8] = noteNum;
			end
			default: ;
		endcase
	end

	// Empty or inverted window would read outside the wave
	assert property (@(posedge sClk) disable iff (!rstN) playEnable |-> waveEnd > waveStart)
		else $error("synthCsr: window end not above start while enabled");

endmodule

//--- rtl/synthTop.sv
// Single-voice wavetable synth, MIDI in, sample memory reads, I2S out
// Everything runs on sClk, the I2S bit clock is divided from it
// Memory channel keeps one read outstanding
`timescale 1ns/1ps

module synthTop
(
	input  logic sClk,
	input  logic rstN,
	// Register bus
	input  logic csrWrEn,
	input  logic [synthPkg::CSR_ADDR_W-1:0] csrAddr,
	input  logic [synthPkg::CSR_DATA_W-1:0] csrWrData,
	output logic [synthPkg::CSR_DATA_W-1:0] csrRdData,
	// MIDI
	input  logic midiIn,
	// Sample memory
	output logic memReqValid,
	input  logic memReqReady,
	output logic [synthPkg::MEM_ADDR_W-1:0] memAddr,
	input  logic memRspValid,
	input  logic [synthPkg::SAMPLE_W-1:0] memRspData,
	// I2S
	output logic i2sBclk,
	output logic i2sLrclk,
	output logic i2sSdata
);

	logic playEnable;
	logic loopEnable;
	logic [synthPkg::MEM_ADDR_W-1:0] waveStart;
	logic [synthPkg::MEM_ADDR_W-1:0] waveEnd;
	logic waveDone;
	logic [7:0] rxByte;
	logic rxValid;
	logic notePlay;
	logic [synthPkg::STEP_W-1:0] noteStep;
	logic [6:0] noteNum;
	logic noteStart;
	logic sampleValid;
	logic sampleReady;
	logic [synthPkg::SAMPLE_W-1:0] sampleData;

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------
	synthCsr u_csr (
		.sClk(sClk), .rstN(rstN),
		.csrWrEn(csrWrEn), .csrAddr(csrAddr),
		.csrWrData(csrWrData), .csrRdData(csrRdData),
		.playEnable(playEnable), .loopEnable(loopEnable),
		.waveStart(waveStart), .waveEnd(waveEnd),
		.waveDone(waveDone), .notePlay(notePlay), .noteNum(noteNum)
	);

	// --------------------------------------------------
	// MIDI path
	// --------------------------------------------------
	midiRx u_midiRx (
		.sClk(sClk), .rstN(rstN),
		.midiIn(midiIn), .rxByte(rxByte), .rxValid(rxValid)
	);

	noteDecoder u_noteDecoder (
		.sClk(sClk), .rstN(rstN),
		.rxByte(rxByte), .rxValid(rxValid),
		.notePlay(notePlay), .noteStep(noteStep),
		.noteNum(noteNum), .noteStart(noteStart)
	);

	// --------------------------------------------------
	// Wave fetch and I2S out
	// --------------------------------------------------
	waveFetch u_waveFetch (
		.sClk(sClk), .rstN(rstN),
		.playEnable(playEnable), .loopEnable(loopEnable),
		.waveStart(waveStart), .waveEnd(waveEnd),
		.notePlay(notePlay), .noteStart(noteStart), .noteStep(noteStep),
		.waveDone(waveDone),
		.memReqValid(memReqValid), .memReqReady(memReqReady), .memAddr(memAddr),
		.memRspValid(memRspValid), .memRspData(memRspData),
		.sampleValid(sampleValid), .sampleReady(sampleReady), .sampleData(sampleData)
	);

	i2sTx u_i2sTx (
		.sClk(sClk), .rstN(rstN),
		.sampleValid(sampleValid), .sampleReady(sampleReady), .sampleData(sampleData),
		.i2sBclk(i2sBclk), .i2sLrclk(i2sLrclk), .i2sSdata(i2sSdata)
	);

	// A full frame without a stalled request leaves no excuse for an underrun
	assert property (@(posedge sClk) disable iff (!rstN)
		(!memReqValid || memReqReady) [*synthPkg::I2S_FRAME_CYCLES] |=> !u_i2sTx.underrun)
		else $error("synthTop: I2S underrun while memory kept up");

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the synth testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f \
	--top-module synthTb \
	-Mdir obj_dir -o synthSim

./obj_dir/synthSim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1

//--- tests/synthTb.sv
// Directed testbench for the wavetable synth top level
// Memory model returns address XOR 16'h5a5a with random ready and response delays
// I2S frames are decoded at the ports, one sample per frame on both channels
// Expected samples come from the phase rule and the octave 0 step table
`timescale 1ns/1ps

module synthTb;

	localparam int CLK_PERIOD_NS = 8;
	localparam int BYTE_CYCLES = 10 * int'(synthPkg::MIDI_BIT_CYCLES);
	localparam int FRAME_CYCLES = synthPkg::I2S_FRAME_CYCLES;
	// Totals over all tests, used by the watchdog
	localparam int TOTAL_MIDI_BYTES = 26;
	localparam int TOTAL_FRAMES = 55;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_MIDI_BYTES * BYTE_CYCLES
		+ TOTAL_FRAMES * FRAME_CYCLES);
	localparam int FRAME_TIMEOUT = 3 * FRAME_CYCLES;
	localparam int SYNC_FRAMES = 4;

	logic sClk;
	logic rstN;
	logic csrWrEn;
	logic [synthPkg::CSR_ADDR_W-1:0] csrAddr;
	logic [synthPkg::CSR_DATA_W-1:0] csrWrData;
	logic [synthPkg::CSR_DATA_W-1:0] csrRdData;
	logic midiIn;
	logic memReqValid;
	logic memReqReady;
	logic [synthPkg::MEM_ADDR_W-1:0] memAddr;
	logic memRspValid;
	logic [synthPkg::SAMPLE_W-1:0] memRspData;
	logic i2sBclk;
	logic i2sLrclk;
	logic i2sSdata;

	// Bookkeeping
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	logic [31:0] lfsrState = 32'h4a73_bb15;
	logic [31:0] frameQ[$];

	// I2S decoder state
	logic prevBclk;
	logic prevLr;
	logic framed;
	int bitCount;
	logic [synthPkg::SAMPLE_W-1:0] leftShift;
	logic [synthPkg::SAMPLE_W-1:0] rightShift;

	// Reference model of the phase rule
	logic [synthPkg::PHASE_W-1:0] modelPhase;
	logic [synthPkg::MEM_ADDR_W-1:0] modelStart;
	logic [synthPkg::MEM_ADDR_W-1:0] modelEnd;
	logic [synthPkg::STEP_W-1:0] modelStep;
	logic modelLoop;
	logic modelRun;

	synthTop u_dut (
		.sClk(sClk), .rstN(rstN),
		.csrWrEn(csrWrEn), .csrAddr(csrAddr),
		.csrWrData(csrWrData), .csrRdData(csrRdData),
		.midiIn(midiIn),
		.memReqValid(memReqValid), .memReqReady(memReqReady), .memAddr(memAddr),
		.memRspValid(memRspValid), .memRspData(memRspData),
		.i2sBclk(i2sBclk), .i2sLrclk(i2sLrclk), .i2sSdata(i2sSdata)
	);

	initial
		sClk = 1'b0;

	always #(CLK_PERIOD_NS / 2) sClk = ~sClk;

	// --------------------------------------------------
	// Random bits and compare helpers
	// --------------------------------------------------
	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int randBits(input int n);
		int value;
		int i;
		value = 0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
		return value;
	endfunction

	task automatic checkData16(input string name, input logic [synthPkg::SAMPLE_W-1:0] got,
		input logic [synthPkg::SAMPLE_W-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkData32(input string name, input logic [synthPkg::CSR_DATA_W-1:0] got,
		input logic [synthPkg::CSR_DATA_W-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errorCount - errorsBefore);
	endtask

	// --------------------------------------------------
	// Memory model
	// --------------------------------------------------
	initial
	begin : memModel
		int stall;
		int delay;
		logic [synthPkg::MEM_ADDR_W-1:0] rspAddr;
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		forever
		begin
			@(posedge sClk);
			if (memReqValid)
			begin
				// Ready held low for 0 to 3 cycles
				stall = randBits(2);
				repeat (stall) @(posedge sClk);
				memReqReady <= 1'b1;
				@(posedge sClk);
				memReqReady <= 1'b0;
				rspAddr = memAddr;
				delay = randBits(2);
				repeat (delay) @(posedge sClk);
				memRspValid <= 1'b1;
				memRspData <= rspAddr[synthPkg::SAMPLE_W-1:0] ^ 16'h5a5a;
				@(posedge sClk);
				memRspValid <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// I2S decoder on the stable half of sClk
	// --------------------------------------------------
	task automatic closeFrame(input logic [synthPkg::SAMPLE_W-1:0] left,
		input logic [synthPkg::SAMPLE_W-1:0] right, input int bits);
		if (bits != 32)
		begin
			$display("I2S frame at %0t ns had %0d bit clocks instead of 32", $time, bits);
			errorCount++;
		end
		checkData16("i2sRight", right, left);
		frameQ.push_back({left, right});
	endtask

	always @(negedge sClk)
	begin
		if (!rstN)
		begin
			prevBclk <= 1'b0;
			prevLr <= 1'b0;
			bitCount <= 0;
			framed <= 1'b0;
		end
		else
		begin
			prevBclk <= i2sBclk;
			if (i2sBclk && !prevBclk)
			begin
				prevLr <= i2sLrclk;
				// Data lags word select by one bit
				if (prevLr)
					rightShift <= {rightShift[synthPkg::SAMPLE_W-2:0], i2sSdata};
				else
					leftShift <= {leftShift[synthPkg::SAMPLE_W-2:0], i2sSdata};
				// Right LSB sits in the first bit of the next frame
				if (prevLr && !i2sLrclk)
				begin
					bitCount <= 0;
					framed <= 1'b1;
					if (framed)
						closeFrame(leftShift, {rightShift[synthPkg::SAMPLE_W-2:0], i2sSdata},
							bitCount + 1);
				end
				else
					bitCount <= bitCount + 1;
			end
		end
	end

	task automatic nextFrame(output logic [synthPkg::SAMPLE_W-1:0] left,
		output logic [synthPkg::SAMPLE_W-1:0] right);
		int waited;
		logic [31:0] frame;
		waited = 0;
		while (frameQ.size() == 0 && waited < FRAME_TIMEOUT)
		begin
			@(posedge sClk);
			waited++;
		end
		if (frameQ.size() == 0)
		begin
			$display("No I2S frame arrived within %0d clock cycles", FRAME_TIMEOUT);
			errorCount++;
			left = '0;
			right = '0;
		end
		else
		begin
			frame = frameQ.pop_front();
			left = frame[31:16];
			right = frame[15:0];
		end
	endtask

	// --------------------------------------------------
	// Bus and MIDI drivers
	// --------------------------------------------------
	task automatic writeReg(input logic [synthPkg::CSR_ADDR_W-1:0] addr,
		input logic [synthPkg::CSR_DATA_W-1:0] data);
		@(posedge sClk);
		csrWrEn <= 1'b1;
		csrAddr <= addr;
		csrWrData <= data;
		@(posedge sClk);
		csrWrEn <= 1'b0;
	endtask

	task automatic checkReg(input string name, input logic [synthPkg::CSR_ADDR_W-1:0] addr,
		input logic [synthPkg::CSR_DATA_W-1:0] exp);
		@(posedge sClk);
		csrAddr <= addr;
		@(posedge sClk);
		checkData32(name, csrRdData, exp);
	endtask

	// 8N1, LSB first
	task automatic sendMidiByte(input logic [7:0] value);
		logic [9:0] bits;
		int i;
		bits = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(posedge sClk);
			midiIn <= bits[i];
			repeat (int'(synthPkg::MIDI_BIT_CYCLES) - 1) @(posedge sClk);
		end
	endtask

	task automatic sendMidiMsg(input logic [7:0] status, input logic [7:0] d0,
		input logic [7:0] d1);
		sendMidiByte(status);
		sendMidiByte(d0);
		sendMidiByte(d1);
	endtask

	// --------------------------------------------------
	// Phase rule model
	// --------------------------------------------------
	function automatic logic [synthPkg::STEP_W-1:0] stepForNote(input int note);
		return synthPkg::STEP_W'(synthPkg::NOTE_BASE_STEP[note % 12] << (note / 12));
	endfunction

	task automatic modelNext(output logic [synthPkg::SAMPLE_W-1:0] expSample);
		logic [synthPkg::MEM_ADDR_W-1:0] addr;
		logic [synthPkg::PHASE_W-1:0] stepped;
		if (!modelRun)
			expSample = '0;
		else
		begin
			addr = modelPhase[synthPkg::PHASE_W-1:synthPkg::FRAC_W];
			expSample = addr[synthPkg::SAMPLE_W-1:0] ^ 16'h5a5a;
			stepped = modelPhase + synthPkg::PHASE_W'(modelStep);
			if (stepped[synthPkg::PHASE_W-1:synthPkg::FRAC_W] >= modelEnd)
			begin
				if (modelLoop)
					modelPhase = {modelStart, {synthPkg::FRAC_W{1'b0}}};
				else
					modelRun = 1'b0;
			end
			else
				modelPhase = stepped;
		end
	endtask

	// Note loaded while disabled so no stale read reaches the output
	task automatic startNote(input int note, input logic [synthPkg::MEM_ADDR_W-1:0] start,
		input logic [synthPkg::MEM_ADDR_W-1:0] stop, input logic loop);
		writeReg(synthPkg::REG_CTRL, 32'd0);
		writeReg(synthPkg::REG_WAVE_START, 32'(start));
		writeReg(synthPkg::REG_WAVE_END, 32'(stop));
		sendMidiMsg(8'h90, 8'(note), 8'd64);
		writeReg(synthPkg::REG_CTRL, {30'd0, loop, 1'b1});
		frameQ.delete();
		modelStart = start;
		modelEnd = stop;
		modelLoop = loop;
		modelStep = stepForNote(note);
		modelPhase = {start, {synthPkg::FRAC_W{1'b0}}};
		modelRun = 1'b1;
	endtask

	task automatic checkPlayback(input int count);
		logic [synthPkg::SAMPLE_W-1:0] left;
		logic [synthPkg::SAMPLE_W-1:0] right;
		logic [synthPkg::SAMPLE_W-1:0] expSample;
		int waited;
		int i;
		waited = 0;
		nextFrame(left, right);
		// Leading zero frames until the first fetched sample
		while (left == '0 && waited < SYNC_FRAMES)
		begin
			nextFrame(left, right);
			waited++;
		end
		if (left == '0)
		begin
			$display("No non-zero sample within %0d frames after the note started", SYNC_FRAMES);
			errorCount++;
		end
		else
		begin
			for (i = 0; i < count; i++)
			begin
				if (i > 0)
					nextFrame(left, right);
				modelNext(expSample);
				checkData16("i2sLeft", left, expSample);
			end
		end
	endtask

	task automatic checkSilence(input int skip, input int count);
		logic [synthPkg::SAMPLE_W-1:0] left;
		logic [synthPkg::SAMPLE_W-1:0] right;
		int i;
		frameQ.delete();
		// Drain samples already in flight
		repeat (skip) nextFrame(left, right);
		for (i = 0; i < count; i++)
		begin
			nextFrame(left, right);
			checkData16("i2sLeft", left, '0);
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic testRegisters();
		int errorsBefore;
		errorsBefore = errorCount;
		writeReg(synthPkg::REG_WAVE_START, 32'h0000_0100);
		writeReg(synthPkg::REG_WAVE_END, 32'h0000_0400);
		writeReg(synthPkg::REG_CTRL, 32'h0000_0001);
		checkReg("csrRdData(WAVE_START)", synthPkg::REG_WAVE_START, 32'h0000_0100);
		checkReg("csrRdData(WAVE_END)", synthPkg::REG_WAVE_END, 32'h0000_0400);
		checkReg("csrRdData(CTRL)", synthPkg::REG_CTRL, 32'h0000_0001);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_0000);
		checkReg("csrRdData(addr 7)", 4'd7, 32'h0000_0000);
		checkReg("csrRdData(addr 15)", 4'd15, 32'h0000_0000);
		reportTest("register access", errorsBefore);
	endtask

	task automatic testPlayback();
		int errorsBefore;
		errorsBefore = errorCount;
		startNote(60, 18'h00100, 18'h00400, 1'b0);
		checkPlayback(8);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3c02);
		reportTest("note playback", errorsBefore);
	endtask

	task automatic testSilence();
		int errorsBefore;
		errorsBefore = errorCount;
		// Note still held, playback disabled
		writeReg(synthPkg::REG_CTRL, 32'd0);
		checkSilence(3, 4);
		// Enabled again after the note is released
		sendMidiMsg(8'h80, 8'd60, 8'd0);
		writeReg(synthPkg::REG_CTRL, 32'h0000_0001);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3c00);
		checkSilence(3, 4);
		reportTest("silence", errorsBefore);
	endtask

	task automatic testLoopAndEnd();
		int errorsBefore;
		errorsBefore = errorCount;
		startNote(60, 18'h00200, 18'h00206, 1'b1);
		checkPlayback(8);
		// One-shot over the same short window
		startNote(60, 18'h00200, 18'h00206, 1'b0);
		checkPlayback(6);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3c03);
		writeReg(synthPkg::REG_CTRL, 32'h0000_0001);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3c02);
		reportTest("loop and one-shot end", errorsBefore);
	endtask

	task automatic testMidiParsing();
		int errorsBefore;
		errorsBefore = errorCount;
		startNote(60, 18'h00100, 18'h00400, 1'b1);
		// Running status, data bytes only
		sendMidiByte(8'd62);
		sendMidiByte(8'd64);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3e02);
		// Note-off for another note
		sendMidiMsg(8'h80, 8'd50, 8'd64);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3e02);
		// Control change shaped like a note release
		sendMidiMsg(8'hb0, 8'd62, 8'd0);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3e02);
		// Velocity zero on the current note
		sendMidiMsg(8'h90, 8'd62, 8'd0);
		checkReg("csrRdData(STATUS)", synthPkg::REG_STATUS, 32'h0000_3e00);
		checkSilence(3, 4);
		reportTest("MIDI parsing", errorsBefore);
	endtask

	// --------------------------------------------------
	// Main sequence and watchdog
	// --------------------------------------------------
	initial
	begin
		rstN = 1'b0;
		csrWrEn = 1'b0;
		csrAddr = '0;
		csrWrData = '0;
		midiIn = 1'b1;
		repeat (2) @(posedge sClk);
		rstN <= 1'b1;

		testRegisters();
		testPlayback();
		testSilence();
		testLoopAndEnd();
		testMidiParsing();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("Watchdog expired after %0d clock cycles, tests did not finish",
			WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- wave/waveFetch.sv
// Phase accumulator and single-outstanding sample reader
// Presents zero without a read when stopped or disabled
// A note change during a read still presents that read once
`timescale 1ns/1ps

module waveFetch
(
	input  logic sClk,
	input  logic rstN,
	input  logic playEnable,
	input  logic loopEnable,
	input  logic [synthPkg::MEM_ADDR_W-1:0] waveStart,
	input  logic [synthPkg::MEM_ADDR_W-1:0] waveEnd,
	input  logic notePlay,
	input  logic noteStart,
	input  logic [synthPkg::STEP_W-1:0] noteStep,
	output logic waveDone,
	output logic memReqValid,
	input  logic memReqReady,
	output logic [synthPkg::MEM_ADDR_W-1:0] memAddr,
	input  logic memRspValid,
	input  logic [synthPkg::SAMPLE_W-1:0] memRspData,
	output logic sampleValid,
	input  logic sampleReady,
	output logic [synthPkg::SAMPLE_W-1:0] sampleData
);

	typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RSP, PRESENT} fetchStateType;

	fetchStateType state;
	logic [synthPkg::PHASE_W-1:0] phase;
	logic [synthPkg::PHASE_W-1:0] nextPhase;
	logic [synthPkg::MEM_ADDR_W-1:0] phaseInt;
	logic [synthPkg::MEM_ADDR_W-1:0] nextInt;
	logic playing;
	logic active;
	logic rspTake;

	assign phaseInt = phase[synthPkg::PHASE_W-1:synthPkg::FRAC_W];
	assign nextPhase = phase + synthPkg::PHASE_W'(noteStep);
	assign nextInt = nextPhase[synthPkg::PHASE_W-1:synthPkg::FRAC_W];
	assign active = playEnable && notePlay && playing;
	assign rspTake = (state == WAIT_RSP) && memRspValid;

	assign memReqValid = state == REQUEST;
	assign sampleValid = state == PRESENT;

	// --------------------------------------------------
	// Fetch FSM and phase
	// --------------------------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			phase <= '0;
			playing <= 1'b0;
			waveDone <= 1'b0;
		end
		else
		begin
			waveDone <= 1'b0;
			case (state)
				// Hold off one cycle on a new note so the phase settles
				IDLE:
				begin
					if (!noteStart)
						state <= active ? REQUEST : PRESENT;
				end
				REQUEST: if (memReqReady) state <= WAIT_RSP;
				WAIT_RSP: if (memRspValid) state <= PRESENT;
				PRESENT: if (sampleReady) state <= IDLE;
				default: state <= IDLE;
			endcase

			if (noteStart)
			begin
				phase <= {waveStart, {synthPkg::FRAC_W{1'b0}}};
				playing <= 1'b1;
			end
			else if (rspTake)
			begin
				// Step after the read, then check the window end
				if (nextInt >= waveEnd)
				begin
					if (loopEnable)
						phase <= {waveStart, {synthPkg::FRAC_W{1'b0}}};
					else
					begin
						playing <= 1'b0;
						waveDone <= 1'b1;
					end
				end
				else
					phase <= nextPhase;
			end
		end
	end

	// Address latched for the whole request, sample held while presented
	always_ff @(posedge sClk)
	begin
		if (state == IDLE && !noteStart)
		begin
			memAddr <= phaseInt;
			if (!active)
				sampleData <= '0;
		end
		else if (rspTake)
			sampleData <= memRspData;
	end

	// --------------------------------------------------
	// Memory channel checks
	// --------------------------------------------------
	assert property (@(posedge sClk) disable iff (!rstN)
		memReqValid && !memReqReady |=> memReqValid && $stable(memAddr))
		else $error("waveFetch: request dropped or address changed while waiting");

	assert property (@(posedge sClk) disable iff (!rstN) memRspValid |-> state == WAIT_RSP)
		else $error("waveFetch: response with no read outstanding");

endmodule
